// File: Bender.yml
package:
  name: ioNxdSubsys

sources:
  # Design, package first
  - files:
      - rtl/ks10IoPkg.sv
      - rtl/cromDecode.sv
      - rtl/nxd.sv
      - rtl/ioFaultLatch.sv
      - rtl/ioNxdSubsys.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tb/ioNxdSubsys_sva.sv
      - tb/ioNxdSubsysTb.sv

// File: ioNxdSubsys.f
rtl/ks10IoPkg.sv
rtl/cromDecode.sv
rtl/nxd.sv
rtl/ioFaultLatch.sv
rtl/ioNxdSubsys.sv
tb/ioNxdSubsys_sva.sv
tb/ioNxdSubsysTb.sv

// File: rtl/cromDecode.sv
//////////////////////////////
// Microword decode
// Clear IO latch strobe and registered end of WRU marker
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cromDecode
   import ks10IoPkg::*;
(
   input  wire  logic clk,
   input  wire  logic rst,
   input  wire  cromT crom,
   output logic       ioClear,
   output logic       wruDone
);

   //////////////////////////////
   // Field extraction
   //////////////////////////////

   // Special function enable
   logic       specEn;
   // Special select code
   logic [0:2] specSel;
   // Current microcode address
   cromAddrT   microAddr;

   assign specEn    = crom[cromSpecEn10Bit];
   assign specSel   = crom[cromSpecSelLo:cromSpecSelHi];
   assign microAddr = crom[cromAddrLo:cromAddrHi];

   //////////////////////////////
   // Clear IO latch
   //////////////////////////////

   // Same cycle as the microword
   assign ioClear = specEn & (specSel == specSelClrIoLat);

   //////////////////////////////
   // End of WRU cycle
   //////////////////////////////

   // Address match, one clock late
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wruDone <= 1'b0;
      end
      else
      begin
         wruDone <= (microAddr == wruDoneAddr);
      end
   end

endmodule

`default_nettype wire

// File: rtl/ioFaultLatch.sv
//////////////////////////////
// IO fault latch
// Holds the NXD fault and its bus address
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ioFaultLatch
   import ks10IoPkg::*;
(
   input  wire  logic    clk,
   input  wire  logic    rst,
   input  wire  logic    ioTimeout,
   input  wire  logic    ioClear,
   input  wire  busAddrT cpuAddr,
   output logic          ioFault,
   output busAddrT       ioFaultAddr
);

   //////////////////////////////
   // Fault flag
   //////////////////////////////

   // Sticky until microcode clears it
   // Timeout has priority over clear
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ioFault <= 1'b0;
      end
      else if (ioTimeout)
      begin
         ioFault <= 1'b1;
      end
      else if (ioClear)
      begin
         ioFault <= 1'b0;
      end
   end

   //////////////////////////////
   // Fault address
   //////////////////////////////

   // CPU holds the address while stalled
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ioFaultAddr <= '0;
      end
      else if (ioTimeout)
      begin
         ioFaultAddr <= cpuAddr;
      end
      else if (ioClear)
      begin
         // Released along with the flag
         ioFaultAddr <= '0;
      end
   end

endmodule

`default_nettype wire

// File: rtl/ioNxdSubsys.sv
//////////////////////////////
// IO NXD subsystem top
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ioNxdSubsys
   import ks10IoPkg::*;
#(
   parameter int ackTimeout = 10
)
(
   input  wire  logic    clk,
   input  wire  logic    rst,
   input  wire  cromT    crom,
   input  wire  busAddrT cpuAddr,
   input  wire  logic    cpuReq,
   input  wire  logic    cpuAck,
   output logic          ioWait,
   output logic          ioBusy,
   output logic          ioFault,
   output busAddrT       ioFaultAddr
);

   // Microword decode outputs
   logic ioClear;
   logic wruDone;
   // Detector to latch
   logic ioTimeout;

   // Microword side
   cromDecode cromDecode_i (
      .clk     (clk),
      .rst     (rst),
      .crom    (crom),
      .ioClear (ioClear),
      .wruDone (wruDone)
   );

   // Acknowledge watchdog
   nxd #(
      .ackTimeout (ackTimeout)
   ) nxd_i (
      .clk       (clk),
      .rst       (rst),
      .cpuAddr   (cpuAddr),
      .cpuReq    (cpuReq),
      .cpuAck    (cpuAck),
      .ioClear   (ioClear),
      .wruDone   (wruDone),
      .ioWait    (ioWait),
      .ioBusy    (ioBusy),
      .ioTimeout (ioTimeout)
   );

   // Fault capture
   ioFaultLatch ioFaultLatch_i (
      .clk         (clk),
      .rst         (rst),
      .ioTimeout   (ioTimeout),
      .ioClear     (ioClear),
      .cpuAddr     (cpuAddr),
      .ioFault     (ioFault),
      .ioFaultAddr (ioFaultAddr)
   );

endmodule

`default_nettype wire

// File: rtl/ks10IoPkg.sv
//////////////////////////////
// KS10 IO bus package
// Bus word, microword and NXD state types with their field positions
//////////////////////////////

`default_nettype none

package ks10IoPkg;

   //////////////////////////////
   // Backplane bus word
   //////////////////////////////

   // Address and control word, bit 0 is the MSB as on the backplane
   typedef logic [0:35] busAddrT;

   // Cycle-kind flags inside the bus word
   localparam int busReadBit  = 3;
   localparam int busWruBit   = 4;
   localparam int busWriteBit = 5;
   localparam int busVectBit  = 6;
   localparam int busPhysBit  = 8;
   localparam int busIoBit    = 9;

   //////////////////////////////
   // Control ROM microword
   //////////////////////////////

   // Full 108 bit microword
   typedef logic [0:107] cromT;

   // Microcode address field
   typedef logic [0:11] cromAddrT;
   localparam int cromAddrLo = 0;
   localparam int cromAddrHi = 11;

   // Special function enable and 3 bit select field
   localparam int cromSpecEn10Bit = 65;
   localparam int cromSpecSelLo   = 66;
   localparam int cromSpecSelHi   = 68;

   // Select code for clear IO latch
   localparam logic [0:2] specSelClrIoLat = 3'b101;

   // Microcode address run at the end of a WRU cycle
   localparam cromAddrT wruDoneAddr = 12'o3726;

   //////////////////////////////
   // NXD state machine
   //////////////////////////////

   typedef enum logic [2:0] {
      IDLE,
      COUNT,
      ACKIO,
      ACKWRU,
      ACKVECT,
      NOACK
   } nxdStateT;

endpackage

`default_nettype wire

// File: rtl/nxd.sv
//////////////////////////////
// Nonexistent device detector
// Stalls the CPU on IO cycles and times out a missing acknowledge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nxd
   import ks10IoPkg::*;
#(
   parameter int ackTimeout = 10
)
(
   input  wire  logic    clk,
   input  wire  logic    rst,
   input  wire  busAddrT cpuAddr,
   input  wire  logic    cpuReq,
   input  wire  logic    cpuAck,
   input  wire  logic    ioClear,
   input  wire  logic    wruDone,
   output logic          ioWait,
   output logic          ioBusy,
   output logic          ioTimeout
);

   // Counter reload value, window fits in 4 bits
   localparam logic [3:0] cntLoad = 4'(ackTimeout);

   //////////////////////////////
   // Bus cycle decode
   //////////////////////////////

   logic busIo;
   logic busWru;
   logic busVect;
   // IO request still waiting for an acknowledge
   logic ioPend;
   // First cycle of a new IO transfer
   logic ioStart;

   assign busIo   = cpuAddr[busIoBit];
   assign busWru  = cpuAddr[busWruBit];
   assign busVect = cpuAddr[busVectBit];
   assign ioPend  = busIo & cpuReq & ~cpuAck;

   //////////////////////////////
   // State and cycle kind
   //////////////////////////////

   nxdStateT   state;
   // Kind captured at start
   logic       wru;
   logic       vect;
   // Busy held after the start cycle
   logic       busy;
   // Acknowledge window
   logic [3:0] nxmCnt;

   assign ioStart = ioPend & (state == IDLE);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= IDLE;
         wru       <= 1'b0;
         vect      <= 1'b0;
         busy      <= 1'b0;
         nxmCnt    <= '0;
         ioTimeout <= 1'b0;
      end
      else
      begin
         // Pulse by default low
         ioTimeout <= 1'b0;
         case (state)
            // Wait for an IO request
            IDLE:
            begin
               if (ioStart)
               begin
                  wru    <= busWru;
                  vect   <= busVect;
                  busy   <= 1'b1;
                  nxmCnt <= cntLoad;
                  state  <= COUNT;
               end
            end
            // Count down until ACK or window expires
            COUNT:
            begin
               if (cpuAck)
               begin
                  if (wru)
                  begin
                     state <= ACKWRU;
                  end
                  else if (vect)
                  begin
                     state <= ACKVECT;
                  end
                  else
                  begin
                     state <= ACKIO;
                  end
               end
               else if (nxmCnt != 4'd0)
               begin
                  nxmCnt <= nxmCnt - 4'd1;
               end
               else
               begin
                  // No device answered
                  ioTimeout <= 1'b1;
                  state     <= NOACK;
               end
            end
            // Plain IO, microcode closes it
            ACKIO:
            begin
               if (ioClear)
               begin
                  busy  <= 1'b0;
                  state <= IDLE;
               end
            end
            // WRU, done at end of WRU microcode
            ACKWRU:
            begin
               if (wruDone)
               begin
                  busy  <= 1'b0;
                  state <= IDLE;
               end
            end
            // Vector, done once the flag leaves the bus
            ACKVECT:
            begin
               if (!busVect)
               begin
                  busy  <= 1'b0;
                  state <= IDLE;
               end
            end
            // Unacknowledged cycle
            NOACK:
            begin
               busy <= 1'b0;
               // WRU lingers until the flag drops
               if (!wru || !busWru)
               begin
                  state <= IDLE;
               end
            end
            default:
            begin
               busy  <= 1'b0;
               state <= IDLE;
            end
         endcase
      end
   end

   //////////////////////////////
   // Outputs
   //////////////////////////////

   // Start term stalls the CPU right away
   assign ioBusy = ioStart | busy;
   assign ioWait = ioStart | (ioPend & (state == COUNT));

endmodule

`default_nettype wire

// File: tb/ioNxdSubsysTb.sv
//////////////////////////////
// IO NXD subsystem testbench
// Table driven bus cycles against a device acknowledge model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ioNxdSubsysTb
   import ks10IoPkg::*;
();

   localparam int ackTimeout = 10;
   // Cycle kinds in the stimulus table
   localparam int kIo   = 0;
   localparam int kWru  = 1;
   localparam int kVect = 2;
   localparam int kMem  = 3;
   // Delay entry for a device that never answers
   localparam int noAck = 0;

   logic    clk = 1'b0;
   logic    rst;
   cromT    crom;
   busAddrT cpuAddr;
   logic    cpuReq;
   logic    cpuAck;
   logic    ioWait;
   logic    ioBusy;
   logic    ioFault;
   busAddrT ioFaultAddr;

   // Stimulus table columns
   int      kindTbl[$];
   busAddrT addrTbl[$];
   int      delayTbl[$];
   logic    faultTbl[$];

   integer  seed = 32'hd5849653;
   int      errors = 0;
   int      checks = 0;
   int      timeouts = 0;
   // Failures seen by the bound assertions
   int      assertFails = 0;
   // Clear IO latch and end of WRU microwords
   cromT    clrWord;
   cromT    wruWord;

   always #50 clk = ~clk;

   ioNxdSubsys #(.ackTimeout(ackTimeout)) ioNxdSubsys_i (.*);

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic checkBit(input logic actual, input logic expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
      end
   endtask

   task automatic checkAddr(input busAddrT actual, input busAddrT expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("FAILED at %0t: %s is %o, expected %o", $time, what, actual, expected);
      end
   endtask

   // Bus word with the flags of one cycle kind
   function automatic busAddrT makeAddr(input int kind, input logic [17:0] low);
      busAddrT a;
      a = '0;
      a[18:35] = low;
      a[busReadBit] = 1'b1;
      a[busIoBit]   = (kind != kMem);
      a[busWruBit]  = (kind == kWru);
      a[busVectBit] = (kind == kVect);
      return a;
   endfunction

   task automatic addEntry(input int kind, input busAddrT addr, input int delay, input logic f);
      kindTbl.push_back(kind);
      addrTbl.push_back(addr);
      delayTbl.push_back(delay);
      faultTbl.push_back(f);
   endtask

   //////////////////////////////
   // Bus cycle players
   //////////////////////////////

   // Memory request, detector stays quiet
   task automatic memCycle(input busAddrT addr);
      int n;
      for (n = 0; n < ackTimeout + 4; n++)
      begin
         @(negedge clk);
         cpuAddr = addr;
         cpuReq  = 1'b1;
         #1;
         checkBit(ioWait, 1'b0, "ioWait on memory cycle");
         checkBit(ioBusy, 1'b0, "ioBusy on memory cycle");
         checkBit(ioFault, 1'b0, "ioFault on memory cycle");
      end
      @(negedge clk);
      cpuReq  = 1'b0;
      cpuAddr = '0;
   endtask

   // Device answers after delay cycles, then the cycle is closed
   task automatic ackCycle(input int kind, input busAddrT addr, input int delay,
                           input logic expFault);
      int n;
      @(negedge clk);
      cpuAddr = addr;
      cpuReq  = 1'b1;
      #1;
      checkBit(ioWait, 1'b1, "ioWait in start cycle");
      checkBit(ioBusy, 1'b1, "ioBusy in start cycle");
      for (n = 1; n <= delay; n++)
      begin
         @(negedge clk);
         cpuAck = (n == delay);
         #1;
         checkBit(ioWait, n != delay, "ioWait while waiting for ack");
         checkBit(ioBusy, 1'b1, "ioBusy while waiting for ack");
      end
      // CPU ends the bus cycle, a vector keeps its flag
      @(negedge clk);
      cpuReq = 1'b0;
      cpuAck = 1'b0;
      if (kind != kVect)
         cpuAddr = '0;
      #1;
      checkBit(ioBusy, 1'b1, "ioBusy after ack");
      // Closing event of the cycle kind
      @(negedge clk);
      if (kind == kIo)
         crom = clrWord;
      else if (kind == kWru)
         crom = wruWord;
      else
         cpuAddr = '0;
      #1;
      checkBit(ioBusy, 1'b1, "ioBusy in closing cycle");
      @(negedge clk);
      crom = '0;
      #1;
      // End of WRU is seen one clock late
      checkBit(ioBusy, kind == kWru, "ioBusy after closing cycle");
      if (kind == kWru)
      begin
         @(negedge clk);
         #1;
         checkBit(ioBusy, 1'b0, "ioBusy after end of WRU");
      end
      checkBit(ioFault, expFault, "ioFault after acknowledged cycle");
   endtask

   // Nobody answers, fault is latched and later cleared
   task automatic noAckCycle(input busAddrT addr, input logic expFault);
      int n;
      @(negedge clk);
      cpuAddr = addr;
      cpuReq  = 1'b1;
      #1;
      n = 0;
      while (ioWait && n < ackTimeout + 8)
      begin
         checkBit(ioFault, 1'b0, "ioFault before timeout");
         @(negedge clk);
         #1;
         n++;
      end
      if (ioWait)
      begin
         $display("Timeout: ioWait still high %0d cycles into an unanswered IO cycle", n);
         timeouts++;
      end
      else
      begin
         // Timeout pulse cycle, latch not yet set
         checkBit(ioFault, 1'b0, "ioFault in timeout pulse cycle");
         // CPU gives up, latch already holds the address
         @(negedge clk);
         cpuReq  = 1'b0;
         cpuAddr = '0;
         #1;
         n++;
         if (n != ackTimeout + 3)
         begin
            errors++;
            $display("FAILED at %0t: fault %0d cycles after start, expected %0d",
                     $time, n, ackTimeout + 3);
         end
         checkBit(ioFault, expFault, "ioFault after timeout");
         checkAddr(ioFaultAddr, addr, "ioFaultAddr after timeout");
         @(negedge clk);
         crom = clrWord;
         #1;
         checkBit(ioFault, 1'b1, "ioFault during clear microword");
         @(negedge clk);
         crom = '0;
         #1;
         checkBit(ioFault, 1'b0, "ioFault after clear");
         checkAddr(ioFaultAddr, '0, "ioFaultAddr after clear");
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      int i;
      int kind;
      rst     = 1'b1;
      crom    = '0;
      cpuAddr = '0;
      cpuReq  = 1'b0;
      cpuAck  = 1'b0;
      clrWord = '0;
      clrWord[cromSpecEn10Bit] = 1'b1;
      clrWord[cromSpecSelLo:cromSpecSelHi] = specSelClrIoLat;
      wruWord = '0;
      wruWord[cromAddrLo:cromAddrHi] = 12'o3726;
      // Directed entries
      addEntry(kIo, makeAddr(kIo, 18'o200104), 3, 1'b0);
      addEntry(kIo, makeAddr(kIo, 18'o777000), noAck, 1'b1);
      addEntry(kWru, makeAddr(kWru, 18'o000003), 2, 1'b0);
      addEntry(kVect, makeAddr(kVect, 18'o000140), 5, 1'b0);
      addEntry(kMem, makeAddr(kMem, 18'o001234), noAck, 1'b0);
      addEntry(kIo, makeAddr(kIo, 18'o200110), ackTimeout, 1'b0);
      addEntry(kWru, makeAddr(kWru, 18'o000001), noAck, 1'b1);
      // Random kinds, delays inside the window
      for (i = 0; i < 16; i++)
      begin
         kind = {$random(seed)} % 3;
         addEntry(kind, makeAddr(kind, 18'($random(seed))),
                  1 + {$random(seed)} % (ackTimeout - 1), 1'b0);
      end
      repeat (10) @(negedge clk);
      rst = 1'b0;
      #1;
      checkBit(ioWait, 1'b0, "ioWait after reset");
      checkBit(ioBusy, 1'b0, "ioBusy after reset");
      checkBit(ioFault, 1'b0, "ioFault after reset");
      checkAddr(ioFaultAddr, '0, "ioFaultAddr after reset");
      for (i = 0; i < kindTbl.size(); i++)
      begin
         if (timeouts != 0)
            break;
         if (kindTbl[i] == kMem)
            memCycle(addrTbl[i]);
         else if (delayTbl[i] == noAck)
            noAckCycle(addrTbl[i], faultTbl[i]);
         else
            ackCycle(kindTbl[i], addrTbl[i], delayTbl[i], faultTbl[i]);
      end
      @(negedge clk);
      assertFails = ioNxdSubsys_i.nxd_i.nxdSva_i.failCount;
      $display("Checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
               checks, errors, timeouts, assertFails);
      if (errors == 0 && timeouts == 0 && assertFails == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/ioNxdSubsys_sva.sv
//////////////////////////////
// NXD assertions
// Pulse, stall and idle rules of the detector
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nxdSva
   import ks10IoPkg::*;
(
   input wire logic     clk,
   input wire logic     rst,
   input wire nxdStateT state,
   input wire busAddrT  cpuAddr,
   input wire logic     cpuReq,
   input wire logic     cpuAck,
   input wire logic     ioWait,
   input wire logic     ioBusy,
   input wire logic     ioTimeout
);

   // Assertion failure count
   int failCount = 0;

   // Timeout is a single clock pulse
   timeoutPulse: assert property (@(posedge clk) disable iff (rst)
      ioTimeout |=> !ioTimeout)
   else
   begin
      failCount++;
      $error("ioTimeout high for more than one cycle");
   end

   // CPU stalled only inside a busy cycle
   waitBusy: assert property (@(posedge clk) disable iff (rst)
      ioWait |-> ioBusy)
   else
   begin
      failCount++;
      $error("ioWait high while ioBusy is low");
   end

   // IDLE left only on an IO request
   idleHold: assert property (@(posedge clk) disable iff (rst)
      ((state == IDLE) && !(cpuReq && cpuAddr[busIoBit] && !cpuAck)) |=> (state == IDLE))
   else
   begin
      failCount++;
      $error("state left IDLE without an IO request");
   end

endmodule

bind nxd nxdSva nxdSva_i (
   .clk       (clk),
   .rst       (rst),
   .state     (state),
   .cpuAddr   (cpuAddr),
   .cpuReq    (cpuReq),
   .cpuAck    (cpuAck),
   .ioWait    (ioWait),
   .ioBusy    (ioBusy),
   .ioTimeout (ioTimeout)
);

`default_nettype wire
